//--- rtl/werewolf_pkg.sv
package werewolf_pkg;

    // --------------------
    // Seats and roles
    // --------------------
    localparam int MAX_PLAYERS = 7;            // Largest count a seat_t can index

    typedef logic [2:0] seat_t;                // Seat index, 7 means nobody
    localparam seat_t SEAT_NONE = 3'd7;

    typedef enum logic [1:0] {
        VILLAGER,
        WOLF,
        MEDIC,
        HIDDEN                                 // Shown outside the seat's own turn
    } role_t;

    typedef logic [5:0] deal_index_t;          // Up to 7*6 = 42 deals

    typedef struct packed {
        seat_t wolf_seat;
        seat_t medic_seat;
    } deal_t;

    // --------------------
    // Game phases
    // --------------------
    typedef enum logic [3:0] {
        IDLE, CLEAR, DEAL,
        NIGHT_SEAT, NIGHT_WAIT, NIGHT_TURN, NIGHT_NEXT, NIGHT_RESOLVE,
        DAWN, DAY_TALK, DAY_VOTE, VOTE_RESOLVE, EXECUTE, CHECK,
        VILLAGE_WON, WOLF_WON
    } phase_t;

    typedef struct packed {
        phase_t      phase;
        seat_t       current_seat;
        role_t       shown_role;
        deal_index_t deal_index;
        logic        vote_taken;
    } game_status_t;

endpackage

//--- rtl/role_table.sv
module role_table #(
    parameter int NUM_PLAYERS = 5
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      clear,
    input  logic                      shuffle,
    output werewolf_pkg::deal_t       deal,
    output werewolf_pkg::deal_index_t deal_index
);

    localparam int NUM_SEEDS = NUM_PLAYERS * (NUM_PLAYERS - 1);
    localparam werewolf_pkg::deal_index_t LAST_INDEX =
        werewolf_pkg::deal_index_t'(NUM_SEEDS - 1);
    localparam werewolf_pkg::deal_index_t GROUP_SIZE =
        werewolf_pkg::deal_index_t'(NUM_PLAYERS - 1);   // Deals per wolf seat

    werewolf_pkg::seat_t wolf;
    werewolf_pkg::seat_t rem;

    // --------------------
    // Deal counter
    // --------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            deal_index <= '0;
        end else if (clear) begin
            deal_index <= '0;
        end else if (shuffle) begin
            if (deal_index == LAST_INDEX) begin
                deal_index <= '0;                    // Wrap modulo NUM_SEEDS
            end else begin
                deal_index <= deal_index + 1'b1;
            end
        end
    end

    // --------------------
    // Index decode
    // --------------------
    // Medic takes slot r among the other seats, so skip over the wolf
    always_comb begin
        wolf = werewolf_pkg::seat_t'(deal_index / GROUP_SIZE);
        rem  = werewolf_pkg::seat_t'(deal_index % GROUP_SIZE);
        deal.wolf_seat  = wolf;
        deal.medic_seat = (rem < wolf) ? rem : rem + 3'd1;
    end

    index_in_range: assert property (
        @(posedge clock) disable iff (reset) deal_index <= LAST_INDEX
    ) else $error("deal_index %0d out of range", deal_index);

endmodule

//--- rtl/player_seat.sv
module player_seat #(
    parameter int SEAT_INDEX = 0
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  deal_strobe,
    input  logic                  night_kill,
    input  logic                  execute,
    input  werewolf_pkg::deal_t   deal,
    input  werewolf_pkg::seat_t   attack_seat,
    input  werewolf_pkg::seat_t   protect_seat,
    input  werewolf_pkg::seat_t   vote_seat,
    output logic                  alive,
    output werewolf_pkg::role_t   role
);

    localparam werewolf_pkg::seat_t MY_SEAT = werewolf_pkg::seat_t'(SEAT_INDEX);

    logic killed;                                       // Attacked and left unprotected

    assign killed = (attack_seat == MY_SEAT) && (protect_seat != MY_SEAT);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            alive <= 1'b1;
            role  <= werewolf_pkg::VILLAGER;
        end else if (deal_strobe) begin
            alive <= 1'b1;                              // New game revives everyone
            if (deal.wolf_seat == MY_SEAT) begin
                role <= werewolf_pkg::WOLF;
            end else if (deal.medic_seat == MY_SEAT) begin
                role <= werewolf_pkg::MEDIC;
            end else begin
                role <= werewolf_pkg::VILLAGER;
            end
        end else if (night_kill && killed) begin
            alive <= 1'b0;
        end else if (execute && vote_seat == MY_SEAT) begin
            alive <= 1'b0;                              // Lynched by the village
        end
    end

    // Death is final until the next deal
    stays_dead: assert property (
        @(posedge clock) disable iff (reset) (!alive && !deal_strobe) |=> !alive
    ) else $error("seat %0d revived without a deal", SEAT_INDEX);

endmodule

//--- rtl/game_tally.sv
module game_tally #(
    parameter int NUM_PLAYERS = 5
) (
    input  logic [NUM_PLAYERS-1:0]                    seat_alive,
    input  werewolf_pkg::role_t [NUM_PLAYERS-1:0]     seat_roles,
    output logic [NUM_PLAYERS-1:0]                    alive,
    output werewolf_pkg::seat_t                       wolf_seat,
    output logic                                      wolf_wins
);

    logic [2:0] living_villagers;                       // Living seats that are not the wolf

    assign alive = seat_alive;

    // --------------------
    // Wolf lookup
    // --------------------
    always_comb begin
        wolf_seat = werewolf_pkg::SEAT_NONE;            // No wolf before the first deal
        for (int i = 0; i < NUM_PLAYERS; i++) begin
            if (seat_roles[i] == werewolf_pkg::WOLF) begin
                wolf_seat = werewolf_pkg::seat_t'(i);
            end
        end
    end

    // --------------------
    // Head count
    // --------------------
    always_comb begin
        living_villagers = '0;
        for (int i = 0; i < NUM_PLAYERS; i++) begin
            if (seat_alive[i] && seat_roles[i] != werewolf_pkg::WOLF) begin
                living_villagers = living_villagers + 3'd1;
            end
        end
    end

    // Wolf can no longer be outvoted
    assign wolf_wins = (living_villagers <= 3'd1);

endmodule

//--- rtl/game_control.sv
module game_control #(
    parameter int NUM_PLAYERS = 5
) (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  start,
    input  logic                                  advance,
    input  logic [NUM_PLAYERS-1:0]                player_buttons,
    input  logic [NUM_PLAYERS-1:0]                alive,
    input  werewolf_pkg::role_t [NUM_PLAYERS-1:0] roles,
    input  werewolf_pkg::seat_t                   wolf_seat,
    input  logic                                  wolf_wins,
    input  werewolf_pkg::deal_index_t             deal_index,
    output logic                                  clear,
    output logic                                  shuffle,
    output logic                                  deal_strobe,
    output logic                                  night_kill,
    output logic                                  execute,
    output werewolf_pkg::seat_t                   attack_seat,
    output werewolf_pkg::seat_t                   protect_seat,
    output werewolf_pkg::seat_t                   vote_seat,
    output werewolf_pkg::game_status_t            status
);

    localparam werewolf_pkg::seat_t LAST_SEAT = werewolf_pkg::seat_t'(NUM_PLAYERS - 1);

    werewolf_pkg::phase_t phase;
    werewolf_pkg::phase_t next_phase;
    werewolf_pkg::seat_t  turn;                         // Seat visited at night
    werewolf_pkg::seat_t  choice;                       // Button latched during a turn
    werewolf_pkg::seat_t  pressed;
    werewolf_pkg::role_t  turn_role;
    logic                 any_press;
    logic                 night_last;                   // CHECK follows a night
    logic                 night_begin;
    logic                 vote_taken;

    // --------------------
    // Button decode
    // --------------------
    always_comb begin
        pressed = werewolf_pkg::SEAT_NONE;
        for (int i = 0; i < NUM_PLAYERS; i++) begin
            if (player_buttons[i]) begin
                pressed = werewolf_pkg::seat_t'(i);
            end
        end
    end

    assign any_press   = |player_buttons;
    assign turn_role   = roles[turn];
    assign night_begin = (next_phase == werewolf_pkg::NIGHT_SEAT)
                      && (phase != werewolf_pkg::NIGHT_NEXT);   // Fresh night, not next seat

    // --------------------
    // Phase FSM
    // --------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            phase <= werewolf_pkg::IDLE;
        end else begin
            phase <= next_phase;
        end
    end

    always_comb begin
        next_phase = phase;                             // Hold by default
        case (phase)
            werewolf_pkg::IDLE,
            werewolf_pkg::VILLAGE_WON,
            werewolf_pkg::WOLF_WON:
                if (start) next_phase = werewolf_pkg::CLEAR;
            werewolf_pkg::CLEAR:
                next_phase = werewolf_pkg::DEAL;
            werewolf_pkg::DEAL:
                if (advance) next_phase = werewolf_pkg::NIGHT_SEAT;
            werewolf_pkg::NIGHT_SEAT:
                next_phase = alive[turn] ? werewolf_pkg::NIGHT_WAIT : werewolf_pkg::NIGHT_NEXT;
            werewolf_pkg::NIGHT_WAIT:
                if (advance) next_phase = werewolf_pkg::NIGHT_TURN;
            werewolf_pkg::NIGHT_TURN:
                if (advance) next_phase = werewolf_pkg::NIGHT_NEXT;
            werewolf_pkg::NIGHT_NEXT:
                next_phase = (turn == LAST_SEAT) ? werewolf_pkg::NIGHT_RESOLVE
                                                 : werewolf_pkg::NIGHT_SEAT;
            werewolf_pkg::NIGHT_RESOLVE:
                next_phase = werewolf_pkg::DAWN;
            werewolf_pkg::DAWN:
                if (advance) next_phase = werewolf_pkg::CHECK;
            werewolf_pkg::DAY_TALK:
                if (advance) next_phase = werewolf_pkg::DAY_VOTE;
            werewolf_pkg::DAY_VOTE:
                if (advance && vote_taken) next_phase = werewolf_pkg::VOTE_RESOLVE;
            werewolf_pkg::VOTE_RESOLVE:
                next_phase = (vote_seat == wolf_seat) ? werewolf_pkg::VILLAGE_WON
                                                      : werewolf_pkg::EXECUTE;
            werewolf_pkg::EXECUTE:
                next_phase = werewolf_pkg::CHECK;
            werewolf_pkg::CHECK:
                if (wolf_wins) begin
                    next_phase = werewolf_pkg::WOLF_WON;
                end else begin
                    next_phase = night_last ? werewolf_pkg::DAY_TALK
                                            : werewolf_pkg::NIGHT_SEAT;
                end
            default:
                next_phase = werewolf_pkg::IDLE;
        endcase
    end

    // --------------------
    // Turn counter and day/night flag
    // --------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            turn       <= '0;
            night_last <= 1'b0;
        end else begin
            if (night_begin) begin
                turn <= '0;
            end else if (phase == werewolf_pkg::NIGHT_NEXT && turn != LAST_SEAT) begin
                turn <= turn + 3'd1;
            end
            if (phase == werewolf_pkg::NIGHT_RESOLVE) begin
                night_last <= 1'b1;
            end else if (phase == werewolf_pkg::EXECUTE) begin
                night_last <= 1'b0;
            end
        end
    end

    // Choice is empty at the start of each turn
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            choice <= werewolf_pkg::SEAT_NONE;
        end else if (phase == werewolf_pkg::NIGHT_WAIT && advance) begin
            choice <= werewolf_pkg::SEAT_NONE;
        end else if (phase == werewolf_pkg::NIGHT_TURN && any_press) begin
            choice <= pressed;
        end
    end

    // --------------------
    // Night actions
    // --------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            attack_seat  <= werewolf_pkg::SEAT_NONE;
            protect_seat <= werewolf_pkg::SEAT_NONE;
        end else if (phase == werewolf_pkg::CLEAR) begin
            attack_seat  <= werewolf_pkg::SEAT_NONE;
            protect_seat <= werewolf_pkg::SEAT_NONE;
        end else if (night_begin) begin
            protect_seat <= werewolf_pkg::SEAT_NONE;    // Protection lasts one night
        end else if (phase == werewolf_pkg::NIGHT_TURN && advance
                     && choice != werewolf_pkg::SEAT_NONE) begin
            if (turn_role == werewolf_pkg::WOLF) begin
                attack_seat <= choice;
            end else if (turn_role == werewolf_pkg::MEDIC) begin
                protect_seat <= choice;
            end
        end
    end

    // --------------------
    // Day vote
    // --------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            vote_seat  <= werewolf_pkg::SEAT_NONE;
            vote_taken <= 1'b0;
        end else if (phase == werewolf_pkg::CLEAR || phase == werewolf_pkg::DAY_TALK) begin
            vote_seat  <= werewolf_pkg::SEAT_NONE;
            vote_taken <= 1'b0;
        end else if (phase == werewolf_pkg::DAY_VOTE && any_press) begin
            vote_taken <= alive[pressed];               // Dead seats can't be voted
            if (alive[pressed]) begin
                vote_seat <= pressed;
            end
        end
    end

    // --------------------
    // Strobes and status
    // --------------------
    assign clear       = (phase == werewolf_pkg::CLEAR);
    assign shuffle     = (phase == werewolf_pkg::DEAL) && !advance;  // Freeze on the pick
    assign deal_strobe = (phase == werewolf_pkg::CLEAR)
                      || (phase == werewolf_pkg::DEAL && advance);
    assign night_kill  = (phase == werewolf_pkg::NIGHT_RESOLVE);
    assign execute     = (phase == werewolf_pkg::EXECUTE);

    assign status = '{
        phase:        phase,
        current_seat: turn,
        shown_role:   (phase == werewolf_pkg::NIGHT_TURN) ? turn_role : werewolf_pkg::HIDDEN,
        deal_index:   deal_index,
        vote_taken:   vote_taken
    };

    turn_seat_alive: assert property (
        @(posedge clock) disable iff (reset)
        (phase == werewolf_pkg::NIGHT_TURN) |-> alive[turn]
    ) else $error("night turn given to dead seat %0d", turn);

    strobes_onehot: assert property (
        @(posedge clock) disable iff (reset)
        $onehot0({shuffle, deal_strobe, night_kill, execute})
    ) else $error("overlapping game strobes");

endmodule

//--- rtl/werewolf_top.sv
module werewolf_top #(
    parameter int NUM_PLAYERS = 5
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       start,
    input  logic                       advance,
    input  logic [NUM_PLAYERS-1:0]     player_buttons,
    output werewolf_pkg::game_status_t status,
    output logic [NUM_PLAYERS-1:0]     alive
);

    logic                                  clear;
    logic                                  shuffle;
    logic                                  deal_strobe;
    logic                                  night_kill;
    logic                                  execute;
    werewolf_pkg::deal_t                   deal;
    werewolf_pkg::deal_index_t             deal_index;
    werewolf_pkg::seat_t                   attack_seat;
    werewolf_pkg::seat_t                   protect_seat;
    werewolf_pkg::seat_t                   vote_seat;
    werewolf_pkg::seat_t                   wolf_seat;
    logic                                  wolf_wins;
    logic [NUM_PLAYERS-1:0]                seat_alive;
    werewolf_pkg::role_t [NUM_PLAYERS-1:0] seat_roles;

    // seat_t only reaches seat 6
    if (NUM_PLAYERS < 3 || NUM_PLAYERS > werewolf_pkg::MAX_PLAYERS) begin : g_bad_count
        $error("NUM_PLAYERS must be 3 to %0d", werewolf_pkg::MAX_PLAYERS);
    end

    role_table #(.NUM_PLAYERS(NUM_PLAYERS)) role_table_i (
        .clock      (clock),
        .reset      (reset),
        .clear      (clear),
        .shuffle    (shuffle),
        .deal       (deal),
        .deal_index (deal_index)
    );

    // --------------------
    // Seats
    // --------------------
    for (genvar i = 0; i < NUM_PLAYERS; i++) begin : g_seat
        player_seat #(.SEAT_INDEX(i)) seat_i (
            .clock        (clock),
            .reset        (reset),
            .deal_strobe  (deal_strobe),
            .night_kill   (night_kill),
            .execute      (execute),
            .deal         (deal),
            .attack_seat  (attack_seat),
            .protect_seat (protect_seat),
            .vote_seat    (vote_seat),
            .alive        (seat_alive[i]),
            .role         (seat_roles[i])
        );
    end

    game_tally #(.NUM_PLAYERS(NUM_PLAYERS)) tally_i (
        .seat_alive (seat_alive),
        .seat_roles (seat_roles),
        .alive      (alive),
        .wolf_seat  (wolf_seat),
        .wolf_wins  (wolf_wins)
    );

    game_control #(.NUM_PLAYERS(NUM_PLAYERS)) control_i (
        .clock          (clock),
        .reset          (reset),
        .start          (start),
        .advance        (advance),
        .player_buttons (player_buttons),
        .alive          (alive),            // Same mask the outputs show
        .roles          (seat_roles),
        .wolf_seat      (wolf_seat),
        .wolf_wins      (wolf_wins),
        .deal_index     (deal_index),
        .clear          (clear),
        .shuffle        (shuffle),
        .deal_strobe    (deal_strobe),
        .night_kill     (night_kill),
        .execute        (execute),
        .attack_seat    (attack_seat),
        .protect_seat   (protect_seat),
        .vote_seat      (vote_seat),
        .status         (status)
    );

endmodule

//--- verif/werewolf_tb.sv
module werewolf_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_PLAYERS = 5;
    localparam int NUM_SEEDS   = NUM_PLAYERS * (NUM_PLAYERS - 1);
    localparam int MAX_CYCLES  = 3000;        // Two games need a few hundred cycles at most
    localparam werewolf_pkg::seat_t NONE = werewolf_pkg::SEAT_NONE;

    logic                       clock;
    logic                       reset;
    logic                       start;
    logic                       advance;
    logic [NUM_PLAYERS-1:0]     player_buttons;
    werewolf_pkg::game_status_t status;
    logic [NUM_PLAYERS-1:0]     alive;

    int                        seed = 32'hebe6;
    int                        cycles = 0;
    werewolf_pkg::deal_index_t picked;        // Deal index seen as the deal froze
    werewolf_pkg::seat_t       atk_seat;      // What the testbench made the wolf pick
    werewolf_pkg::seat_t       prot_seat;
    werewolf_pkg::seat_t       vote_target;
    logic                      press_alive;
    int                        wolf_seen;
    int                        medic_seen;
    logic                      first_night;
    int                        others;        // Living seats that are not the wolf

    werewolf_top #(.NUM_PLAYERS(NUM_PLAYERS)) dut_i (
        .clock          (clock),
        .reset          (reset),
        .start          (start),
        .advance        (advance),
        .player_buttons (player_buttons),
        .status         (status),
        .alive          (alive)
    );

    always #50 clock = ~clock;

    // --------------------
    // Reference model
    // --------------------
    function automatic int wolf_of(input werewolf_pkg::deal_index_t k);
        return int'(k) / (NUM_PLAYERS - 1);
    endfunction

    // Deal k puts the wolf at k/(N-1), medic at remainder, skipping the wolf
    function automatic werewolf_pkg::role_t role_for(input werewolf_pkg::deal_index_t k,
                                                     input werewolf_pkg::seat_t seat);
        int wolf;
        int medic;
        wolf  = wolf_of(k);
        medic = int'(k) % (NUM_PLAYERS - 1);
        if (medic >= wolf) medic = medic + 1;
        if (int'(seat) == wolf) return werewolf_pkg::WOLF;
        if (int'(seat) == medic) return werewolf_pkg::MEDIC;
        return werewolf_pkg::VILLAGER;
    endfunction

    // Counter steps while players wait, holds on the pick
    function automatic int next_deal(input werewolf_pkg::deal_index_t k, input logic pick);
        if (pick) return int'(k);
        return (int'(k) + 1) % NUM_SEEDS;
    endfunction

    // Night starts at seat 0 and walks upward
    function automatic int seat_after(input werewolf_pkg::phase_t prev,
                                      input werewolf_pkg::seat_t seat);
        return (prev == werewolf_pkg::NIGHT_NEXT) ? int'(seat) + 1 : 0;
    endfunction

    always_comb begin
        press_alive = 1'b0;
        others      = 0;
        for (int i = 0; i < NUM_PLAYERS; i++) begin
            if (player_buttons[i]) begin
                press_alive = alive[i];
            end
            if (alive[i] && i != wolf_of(picked)) others = others + 1;
        end
    end

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("** Error at %0t: %s expected %0d, actual %0d", $time, name, expected, actual);
        $display("Simulation failed");
        $fatal(1, "check on %s", name);
    endtask

    // --------------------
    // Checks
    // --------------------
    idle_all_alive: assert property (@(posedge clock) disable iff (reset)
        (status.phase == werewolf_pkg::IDLE || status.phase == werewolf_pkg::DEAL) |-> &alive
    ) else report_mismatch("alive", (1 << NUM_PLAYERS) - 1, int'(alive));

    deal_cleared: assert property (@(posedge clock) disable iff (reset)
        (status.phase == werewolf_pkg::CLEAR) |=> status.deal_index == '0
    ) else report_mismatch("deal_index", 0, int'(status.deal_index));

    deal_step: assert property (@(posedge clock) disable iff (reset)
        (status.phase == werewolf_pkg::DEAL)
            |=> int'(status.deal_index) == next_deal($past(status.deal_index), $past(advance))
    ) else report_mismatch("deal_index", next_deal($past(status.deal_index), $past(advance)),
                           int'(status.deal_index));

    seat_order: assert property (@(posedge clock) disable iff (reset)
        (status.phase == werewolf_pkg::NIGHT_SEAT)
            |-> int'(status.current_seat)
                == seat_after($past(status.phase), $past(status.current_seat))
    ) else report_mismatch("current_seat",
                           seat_after($past(status.phase), $past(status.current_seat)),
                           int'(status.current_seat));

    hidden_outside_turn: assert property (@(posedge clock) disable iff (reset)
        (status.phase != werewolf_pkg::NIGHT_TURN) |-> status.shown_role == werewolf_pkg::HIDDEN
    ) else report_mismatch("shown_role", int'(werewolf_pkg::HIDDEN), int'(status.shown_role));

    turn_role: assert property (@(posedge clock) disable iff (reset)
        (status.phase == werewolf_pkg::NIGHT_TURN)
            |-> status.shown_role == role_for(picked, status.current_seat)
    ) else report_mismatch("shown_role", int'(role_for(picked, status.current_seat)),
                           int'(status.shown_role));

    one_wolf_one_medic: assert property (@(posedge clock) disable iff (reset)
        (status.phase == werewolf_pkg::NIGHT_RESOLVE && first_night)
            |-> wolf_seen == 1 && medic_seen == 1
    ) else report_mismatch("wolf_seen*10+medic_seen", 11, wolf_seen * 10 + medic_seen);

    turn_alive: assert property (@(posedge clock) disable iff (reset)
        (status.phase == werewolf_pkg::NIGHT_TURN) |-> alive[status.current_seat]
    ) else report_mismatch("alive[current_seat]", 1, 0);

    // Victim survives only under the medic's protection
    night_death: assert property (@(posedge clock) disable iff (reset)
        (status.phase == werewolf_pkg::NIGHT_RESOLVE && atk_seat != NONE)
            |=> alive[atk_seat] == (atk_seat == prot_seat)
    ) else report_mismatch("alive[attack]", int'(atk_seat == prot_seat), int'(alive[atk_seat]));

    vote_flag: assert property (@(posedge clock) disable iff (reset)
        (status.phase == werewolf_pkg::DAY_VOTE && |player_buttons)
            |=> status.vote_taken == $past(press_alive)
    ) else report_mismatch("vote_taken", int'($past(press_alive)), int'(status.vote_taken));

    lynched_dead: assert property (@(posedge clock) disable iff (reset)
        (status.phase == werewolf_pkg::EXECUTE) |=> !alive[vote_target]
    ) else report_mismatch("alive[vote]", 0, 1);

    village_win: assert property (@(posedge clock) disable iff (reset)
        (status.phase == werewolf_pkg::VOTE_RESOLVE && int'(vote_target) == wolf_of(picked))
            |=> status.phase == werewolf_pkg::VILLAGE_WON
    ) else report_mismatch("phase", int'(werewolf_pkg::VILLAGE_WON), int'(status.phase));

    wolf_win: assert property (@(posedge clock) disable iff (reset)
        (status.phase == werewolf_pkg::CHECK && others <= 1)
            |=> status.phase == werewolf_pkg::WOLF_WON
    ) else report_mismatch("phase", int'(werewolf_pkg::WOLF_WON), int'(status.phase));

    outcome_holds: assert property (@(posedge clock) disable iff (reset)
        ((status.phase == werewolf_pkg::VILLAGE_WON || status.phase == werewolf_pkg::WOLF_WON)
            && !start) |=> status.phase == $past(status.phase)
    ) else report_mismatch("phase", int'($past(status.phase)), int'(status.phase));

    // --------------------
    // Stimulus
    // --------------------
    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("Timeout: the games did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    task automatic pulse_advance;
        @(posedge clock) advance <= 1'b1;
        @(posedge clock) advance <= 1'b0;
    endtask

    task automatic press(input int seat);
        @(posedge clock) player_buttons <= NUM_PLAYERS'(1) << seat;
        @(posedge clock) player_buttons <= '0;
    endtask

    // Lowest living seat other than the wolf, read at a falling edge
    function automatic int first_target;
        for (int i = 0; i < NUM_PLAYERS; i++) begin
            if (alive[i] && i != wolf_of(picked)) return i;
        end
        return 0;
    endfunction

    task automatic take_turn(input bit village_game);
        int target;
        target = first_target();
        case (status.shown_role)
            werewolf_pkg::WOLF: begin
                wolf_seen = wolf_seen + 1;
                atk_seat  = werewolf_pkg::seat_t'(target);
                press(target);
            end
            werewolf_pkg::MEDIC: begin
                medic_seen = medic_seen + 1;
                if (!village_game) target = wolf_of(picked);    // Wasted protection
                prot_seat = werewolf_pkg::seat_t'(target);
                press(target);
            end
            default: press($unsigned($random(seed)) % NUM_PLAYERS);  // Ignored press
        endcase
        pulse_advance();
    endtask

    task automatic run_night(input bit village_game);
        bit in_night;
        prot_seat = NONE;
        in_night  = 1'b1;
        while (in_night) begin
            @(negedge clock);
            case (status.phase)
                werewolf_pkg::NIGHT_WAIT: pulse_advance();
                werewolf_pkg::NIGHT_TURN: take_turn(village_game);
                werewolf_pkg::DAWN: begin
                    pulse_advance();
                    in_night = 1'b0;
                end
                default: ;
            endcase
        end
        do @(negedge clock);
        while (status.phase != werewolf_pkg::DAY_TALK && status.phase != werewolf_pkg::WOLF_WON);
    endtask

    task automatic run_day(input bit village_game);
        first_night = 1'b0;
        pulse_advance();
        do @(negedge clock); while (status.phase != werewolf_pkg::DAY_VOTE);
        if (!village_game) begin
            for (int i = 0; i < NUM_PLAYERS; i++) begin
                if (!alive[i]) begin
                    press(i);                           // Must not count
                    break;
                end
            end
        end
        vote_target = werewolf_pkg::seat_t'(village_game ? wolf_of(picked) : first_target());
        press(int'(vote_target));
        pulse_advance();
        do @(negedge clock);
        while (status.phase != werewolf_pkg::NIGHT_WAIT
               && status.phase != werewolf_pkg::VILLAGE_WON
               && status.phase != werewolf_pkg::WOLF_WON);
    endtask

    task automatic start_game;
        @(posedge clock) start <= 1'b1;
        @(posedge clock) start <= 1'b0;
        do @(negedge clock); while (status.phase != werewolf_pkg::DEAL);
    endtask

    task automatic play_game(input bit village_game);
        bit done;
        atk_seat = NONE;
        start_game();
        // At least one full lap so the counter wraps
        repeat (NUM_SEEDS + $unsigned($random(seed)) % NUM_SEEDS) @(posedge clock);
        @(posedge clock) advance <= 1'b1;
        @(negedge clock) picked = status.deal_index;    // Index the seats load
        @(posedge clock) advance <= 1'b0;
        wolf_seen   = 0;
        medic_seen  = 0;
        first_night = 1'b1;
        done        = 1'b0;
        while (!done) begin
            run_night(village_game);
            if (status.phase == werewolf_pkg::WOLF_WON) begin
                done = 1'b1;
            end else begin
                run_day(village_game);
                done = (status.phase != werewolf_pkg::NIGHT_WAIT);
            end
        end
        repeat (4) @(posedge clock);                    // Outcome must hold
    endtask

    initial begin
        clock          = 1'b0;
        reset          = 1'b1;
        start          = 1'b0;
        advance        = 1'b0;
        player_buttons = '0;
        picked         = '0;
        atk_seat       = NONE;
        prot_seat      = NONE;
        vote_target    = NONE;
        wolf_seen      = 0;
        medic_seen     = 0;
        first_night    = 1'b0;
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        repeat (2) @(posedge clock);
        play_game(1'b1);
        play_game(1'b0);
        start_game();                                   // Dead seats revive on restart
        repeat (2) @(posedge clock);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- src.f
rtl/werewolf_pkg.sv
rtl/role_table.sv
rtl/player_seat.sv
rtl/game_tally.sv
rtl/game_control.sv
rtl/werewolf_top.sv
verif/werewolf_tb.sv

//--- run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module werewolf_tb \
    -Mdir build -o werewolf_sim

./build/werewolf_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
